/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_core
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* byte_fifo.sv */
`timescale 1ns/1ns

module byte_fifo #(
   parameter int unsigned DEPTH = 4
) (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   input  logic                                 push_i,
   input  logic [uart_frame_pkg::data_bits-1:0] push_data_i,
   input  logic                                 pop_i,
   output logic [uart_frame_pkg::data_bits-1:0] pop_data_o,
   output logic                                 full_o,
   output logic                                 empty_o,
   output logic                                 overflow_o
);

   localparam int unsigned addr_w = $clog2(DEPTH); // DEPTH is at least 2

   logic [uart_frame_pkg::data_bits-1:0] mem [DEPTH];
   logic [addr_w:0]                      wr_ptr;
   logic [addr_w:0]                      rd_ptr;
   logic                                 do_push;
   logic                                 do_pop;

   // The extra pointer bit tells a full FIFO from an empty one
   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

   assign do_pop = pop_i && !empty_o;
   assign do_push = push_i && (!full_o || do_pop); // A pop frees the slot in the same cycle

   assign pop_data_o = mem[rd_ptr[addr_w-1:0]]; // Show-ahead head

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         overflow_o <= 1'b0;
      end else begin
         overflow_o <= push_i && !do_push;
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr[addr_w-1:0]] <= push_data_i;
      end
   end

endmodule

/* files.f */
uart_frame_pkg.sv
uart_fsm_pkg.sv
byte_fifo.sv
uart_receiver.sv
uart_transmitter.sv
uart_core.sv
tb_uart_core.sv

/* tb_uart_core.sv */
`timescale 1ns/1ns

module tb_uart_core;

   localparam int clk_half = 4;
   localparam int tx_depth = 4;
   localparam int rx_depth = 4;
   localparam int div_fast = 15;
   localparam int div_slow = 40;
   localparam int loop_bytes = 12;
   localparam int direct_frames = 2 + rx_depth + 1 + 1; // Framing, overrun and enable tests
   localparam int cycle_limit = (loop_bytes * 10 * (div_fast + 1) +
                                 loop_bytes * 10 * (div_slow + 1) +
                                 direct_frames * 10 * (div_fast + 1)) * 3 / 2;

   logic                                  clk_i = 1'b0;
   logic                                  rst_i;
   logic [uart_frame_pkg::baud_div_w-1:0] baud_div;
   logic                                  rx_en;
   logic                                  tx_en;
   logic                                  loopback;
   logic                                  drv_line;
   logic                                  rx_line;
   logic                                  tx_line;
   logic [uart_frame_pkg::data_bits-1:0]  tx_data;
   logic                                  tx_wr;
   logic                                  tx_full;
   logic                                  tx_busy;
   logic [uart_frame_pkg::data_bits-1:0]  rx_data;
   logic                                  rx_rd;
   logic                                  rx_empty;
   logic                                  rx_frame_err;
   logic                                  rx_overrun;

   logic [7:0]  sent_q[$]; // Bytes still to appear on tx_o
   logic [7:0]  exp_q[$];  // Bytes still to be read from the rx FIFO
   logic [31:0] lcg_state = 32'd40;
   int          errors = 0;
   int          cycle_cnt = 0;
   int          frame_err_cnt = 0;
   int          overrun_cnt = 0;

   assign rx_line = loopback ? tx_line : drv_line;

   uart_core #(
      .TX_DEPTH (tx_depth),
      .RX_DEPTH (rx_depth)
   ) dut0 (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .baud_div_i     (baud_div),
      .rx_en_i        (rx_en),
      .tx_en_i        (tx_en),
      .rx_i           (rx_line),
      .tx_o           (tx_line),
      .tx_data_i      (tx_data),
      .tx_wr_i        (tx_wr),
      .tx_full_o      (tx_full),
      .tx_busy_o      (tx_busy),
      .rx_data_o      (rx_data),
      .rx_rd_i        (rx_rd),
      .rx_empty_o     (rx_empty),
      .rx_frame_err_o (rx_frame_err),
      .rx_overrun_o   (rx_overrun)
   );

   always #(clk_half) clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (rx_frame_err) frame_err_cnt <= frame_err_cnt + 1;
      if (rx_overrun) overrun_cnt <= overrun_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Timeout after %0d cycles with receiver in %s and transmitter in %s",
                  cycle_cnt, dut0.uart_receiver0.state.name(),
                  dut0.uart_transmitter0.state.name());
         $display("Error count: %0d", errors);
         $display("test failed");
         $finish;
      end
   end

   assert property (@(posedge clk_i) disable iff (!rst_i) rx_frame_err |=> !rx_frame_err)
      else begin
         errors++;
         $display("rx_frame_err_o stayed high for more than one cycle at %0t ns", $time);
      end

   assert property (@(posedge clk_i) disable iff (!rst_i) rx_overrun |=> !rx_overrun)
      else begin
         errors++;
         $display("rx_overrun_o stayed high for more than one cycle at %0t ns", $time);
      end

   assert property (@(posedge clk_i) disable iff (!rst_i)
                    !tx_busy |-> tx_line == uart_frame_pkg::line_idle)
      else begin
         errors++;
         $display("tx_o left the idle level while the transmitter was idle at %0t ns", $time);
      end

   task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         errors++;
         $display("MISMATCH at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("Error at %0t ns: %s", $time, what);
   endtask

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic random_byte(output logic [7:0] b);
      lcg_state = lcg_step(lcg_state);
      b = lcg_state[23:16]; // Low bits of an LCG repeat with a short period
   endtask

   task automatic write_byte(input logic [7:0] b);
      @(posedge clk_i);
      while (tx_full) @(posedge clk_i);
      tx_data <= b;
      tx_wr   <= 1'b1;
      sent_q.push_back(b);
      exp_q.push_back(b);
      @(posedge clk_i);
      tx_wr <= 1'b0;
   endtask

   task automatic read_bytes(input int n);
      logic [7:0] want;
      repeat (n) begin
         @(posedge clk_i);
         while (rx_empty) @(posedge clk_i);
         want = '0;
         assert (exp_q.size() != 0)
            else report_failure("a byte was received that was never sent");
         if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
         end
         expect_value("rx_data_o", 32'(want), 32'(rx_data));
         rx_rd <= 1'b1;
         @(posedge clk_i);
         rx_rd <= 1'b0;
      end
   endtask

   task automatic send_frame(input logic [7:0] b, input logic stop_level);
      logic [9:0] frame;
      frame = {stop_level, b, uart_frame_pkg::start_bit};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk_i);
         drv_line <= frame[0];
         frame = frame >> 1;
         repeat (baud_div) @(posedge clk_i);
      end
   endtask

   task automatic idle_line(input int periods);
      @(posedge clk_i);
      drv_line <= uart_frame_pkg::line_idle;
      repeat (periods * (int'(baud_div) + 1)) @(posedge clk_i);
   endtask

   task automatic run_loopback(input int div);
      logic [7:0] b;
      @(posedge clk_i);
      baud_div <= div[uart_frame_pkg::baud_div_w-1:0];
      loopback <= 1'b1;
      fork
         begin
            repeat (loop_bytes) begin
               random_byte(b);
               write_byte(b);
            end
         end
         read_bytes(loop_bytes);
      join
      while (tx_busy) @(posedge clk_i);
      @(posedge clk_i);
      loopback <= 1'b0;
   endtask

   // Checks every frame on tx_o bit by bit against the bytes written
   initial begin : frame_sampler
      logic [7:0] exp_byte;
      logic       exp_bit;
      int         bit_len;
      wait (rst_i == 1'b1);
      forever begin
         @(posedge clk_i);
         if (tx_line == uart_frame_pkg::start_bit) begin
            bit_len = int'(baud_div) + 1;
            exp_byte = '0;
            assert (sent_q.size() != 0)
               else report_failure("a frame started on tx_o with no byte written");
            if (sent_q.size() != 0) begin
               exp_byte = sent_q.pop_front();
            end
            for (int b = 0; b < 10; b++) begin
               if (b == 0) begin
                  exp_bit = uart_frame_pkg::start_bit;
               end else if (b == 9) begin
                  exp_bit = uart_frame_pkg::stop_bit;
               end else begin
                  exp_bit = exp_byte[0];
                  exp_byte = exp_byte >> 1;
               end
               for (int c = 0; c < bit_len; c++) begin
                  if (b != 0 || c != 0) @(posedge clk_i);
                  expect_value("tx_o", 32'(exp_bit), 32'(tx_line));
               end
            end
         end
      end
   end

   initial begin : main
      int         fe0;
      int         ov0;
      logic [7:0] b;
      rst_i    <= 1'b0;
      baud_div <= div_fast[uart_frame_pkg::baud_div_w-1:0];
      rx_en    <= 1'b1;
      tx_en    <= 1'b1;
      loopback <= 1'b0;
      drv_line <= uart_frame_pkg::line_idle;
      tx_data  <= '0;
      tx_wr    <= 1'b0;
      rx_rd    <= 1'b0;
      repeat (8) @(posedge clk_i);
      rst_i <= 1'b1;
      repeat (2) @(posedge clk_i);
      expect_value("tx_o", 32'(uart_frame_pkg::line_idle), 32'(tx_line));
      expect_value("tx_busy_o", 32'd0, 32'(tx_busy));
      expect_value("tx_full_o", 32'd0, 32'(tx_full));
      expect_value("rx_empty_o", 32'd1, 32'(rx_empty));
      repeat (40) @(posedge clk_i);
      expect_value("rx_frame_err_o pulses", 32'd0, 32'(frame_err_cnt));
      expect_value("rx_overrun_o pulses", 32'd0, 32'(overrun_cnt));

      run_loopback(div_fast);
      run_loopback(div_slow);

      baud_div <= div_fast[uart_frame_pkg::baud_div_w-1:0];
      fe0 = frame_err_cnt;
      random_byte(b);
      send_frame(b, 1'b0); // Stop bit held low
      idle_line(2);
      expect_value("rx_frame_err_o pulses", 32'(fe0 + 1), 32'(frame_err_cnt));
      expect_value("rx_empty_o", 32'd1, 32'(rx_empty));
      random_byte(b);
      exp_q.push_back(b);
      send_frame(b, uart_frame_pkg::stop_bit);
      idle_line(1);
      read_bytes(1);

      ov0 = overrun_cnt;
      for (int i = 0; i <= rx_depth; i++) begin
         random_byte(b);
         if (i < rx_depth) exp_q.push_back(b); // The last frame finds the FIFO full
         send_frame(b, uart_frame_pkg::stop_bit);
      end
      idle_line(2);
      expect_value("rx_overrun_o pulses", 32'(ov0 + 1), 32'(overrun_cnt));
      read_bytes(rx_depth);
      @(posedge clk_i);
      expect_value("rx_empty_o", 32'd1, 32'(rx_empty));

      fe0 = frame_err_cnt;
      ov0 = overrun_cnt;
      rx_en <= 1'b0;
      random_byte(b);
      send_frame(b, uart_frame_pkg::stop_bit);
      idle_line(1);
      rx_en <= 1'b1;
      idle_line(2);
      expect_value("rx_empty_o", 32'd1, 32'(rx_empty));
      expect_value("rx_frame_err_o pulses", 32'(fe0), 32'(frame_err_cnt));
      expect_value("rx_overrun_o pulses", 32'(ov0), 32'(overrun_cnt));

      assert (sent_q.size() == 0 && exp_q.size() == 0)
         else report_failure("bytes were never seen");
      $display("Error count: %0d", errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* uart_core.sv */
`timescale 1ns/1ns

module uart_core #(
   parameter int unsigned TX_DEPTH = 4,
   parameter int unsigned RX_DEPTH = 4
) (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic [uart_frame_pkg::baud_div_w-1:0] baud_div_i,
   input  logic                                  rx_en_i,
   input  logic                                  tx_en_i,
   input  logic                                  rx_i,
   output logic                                  tx_o,
   input  logic [uart_frame_pkg::data_bits-1:0]  tx_data_i,
   input  logic                                  tx_wr_i,
   output logic                                  tx_full_o,
   output logic                                  tx_busy_o,
   output logic [uart_frame_pkg::data_bits-1:0]  rx_data_o,
   input  logic                                  rx_rd_i,
   output logic                                  rx_empty_o,
   output logic                                  rx_frame_err_o,
   output logic                                  rx_overrun_o
);

   logic                                 tx_fifo_empty;
   logic [uart_frame_pkg::data_bits-1:0] tx_fifo_data;
   logic                                 tx_fifo_pop;
   logic                                 rx_done;
   logic [uart_frame_pkg::data_bits-1:0] rx_byte;

   byte_fifo #(
      .DEPTH (TX_DEPTH)
   ) tx_fifo0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (tx_wr_i),
      .push_data_i (tx_data_i),
      .pop_i       (tx_fifo_pop),
      .pop_data_o  (tx_fifo_data),
      .full_o      (tx_full_o),
      .empty_o     (tx_fifo_empty),
      .overflow_o  ()             // Host watches tx_full_o instead
   );

   uart_transmitter uart_transmitter0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .tx_en_i      (tx_en_i),
      .baud_div_i   (baud_div_i),
      .fifo_empty_i (tx_fifo_empty),
      .fifo_data_i  (tx_fifo_data),
      .fifo_pop_o   (tx_fifo_pop),
      .tx_o         (tx_o),
      .tx_busy_o    (tx_busy_o)
   );

   uart_receiver uart_receiver0 (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .rx_i           (rx_i),
      .rx_en_i        (rx_en_i),
      .baud_div_i     (baud_div_i),
      .rx_data_o      (rx_byte),
      .rx_done_o      (rx_done),
      .rx_frame_err_o (rx_frame_err_o)
   );

   byte_fifo #(
      .DEPTH (RX_DEPTH)
   ) rx_fifo0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (rx_done),
      .push_data_i (rx_byte),
      .pop_i       (rx_rd_i),
      .pop_data_o  (rx_data_o),
      .full_o      (),
      .empty_o     (rx_empty_o),
      .overflow_o  (rx_overrun_o) // A byte lost to a full FIFO
   );

endmodule

/* uart_frame_pkg.sv */
package uart_frame_pkg;

   // Fixed line format of 8N1 with the LSB sent first

   localparam int unsigned data_bits = 8; // Data bits per frame

   localparam int unsigned baud_div_w = 16; // Width of the bit period divisor

   localparam int unsigned bit_cnt_w = $clog2(data_bits);

   localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(data_bits - 1); // Index of the MSB

   localparam logic line_idle = 1'b1; // Level of a quiet line

   localparam logic start_bit = 1'b0;

   localparam logic stop_bit = 1'b1;

endpackage

/* uart_fsm_pkg.sv */
package uart_fsm_pkg;

   typedef enum logic [1:0] {
      rx_idle, // Waiting for a start bit to reach mid-bit
      rx_data,
      rx_stop  // Also holds here while a break keeps the line low
   } rx_state_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start,
      tx_data,
      tx_stop
   } tx_state_t;

endpackage

/* uart_receiver.sv */
`timescale 1ns/1ns

module uart_receiver (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  rx_i,
   input  logic                                  rx_en_i,
   input  logic [uart_frame_pkg::baud_div_w-1:0] baud_div_i,
   output logic [uart_frame_pkg::data_bits-1:0]  rx_data_o,
   output logic                                  rx_done_o,
   output logic                                  rx_frame_err_o
);

   uart_fsm_pkg::rx_state_t               state;
   logic [1:0]                            rx_sync;
   logic [uart_frame_pkg::baud_div_w-1:0] period_cnt;
   logic [uart_frame_pkg::bit_cnt_w-1:0]  bit_cnt;
   logic [uart_frame_pkg::data_bits-1:0]  shift_q;
   logic                                  break_seen;
   logic                                  rx_bit;
   logic                                  period_end;
   logic                                  sample_data;
   logic                                  stop_ok;

   assign rx_bit = rx_sync[1];
   assign period_end = (period_cnt == baud_div_i);
   assign sample_data = rx_en_i && (state == uart_fsm_pkg::rx_data) && period_end;
   assign stop_ok = rx_en_i && (state == uart_fsm_pkg::rx_stop) && period_end &&
                    (rx_bit == uart_frame_pkg::stop_bit) && !break_seen;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         rx_sync        <= {2{uart_frame_pkg::line_idle}};
         state          <= uart_fsm_pkg::rx_idle;
         period_cnt     <= '0;
         bit_cnt        <= '0;
         break_seen     <= 1'b0;
         rx_done_o      <= 1'b0;
         rx_frame_err_o <= 1'b0;
      end else begin
         rx_sync        <= {rx_sync[0], rx_i}; // Runs even while disabled
         rx_done_o      <= 1'b0;
         rx_frame_err_o <= 1'b0;
         if (rx_en_i) begin
            case (state)
               uart_fsm_pkg::rx_idle: begin
                  if (rx_bit != uart_frame_pkg::start_bit) begin
                     period_cnt <= '0; // A short glitch is not a start bit
                  end else if (period_cnt == (baud_div_i >> 1)) begin
                     state      <= uart_fsm_pkg::rx_data;
                     period_cnt <= '0;
                     bit_cnt    <= '0;
                  end else begin
                     period_cnt <= period_cnt + 1'b1;
                  end
               end
               uart_fsm_pkg::rx_data: begin
                  if (period_end) begin
                     period_cnt <= '0;
                     if (bit_cnt == uart_frame_pkg::last_bit) begin
                        state   <= uart_fsm_pkg::rx_stop;
                        bit_cnt <= '0;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                  end else begin
                     period_cnt <= period_cnt + 1'b1;
                  end
               end
               uart_fsm_pkg::rx_stop: begin
                  if (!period_end) begin
                     period_cnt <= period_cnt + 1'b1;
                  end else if (rx_bit == uart_frame_pkg::stop_bit) begin
                     state      <= uart_fsm_pkg::rx_idle;
                     period_cnt <= '0;
                     break_seen <= 1'b0;
                     rx_done_o  <= !break_seen;
                  end else if (!break_seen) begin
                     // A low stop bit keeps the state here until the line goes high again
                     rx_frame_err_o <= 1'b1;
                     break_seen     <= 1'b1;
                  end
               end
               default: begin
                  state <= uart_fsm_pkg::rx_idle;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (sample_data) begin
         shift_q <= {rx_bit, shift_q[uart_frame_pkg::data_bits-1:1]}; // LSB arrives first
      end
      if (stop_ok) begin
         rx_data_o <= shift_q;
      end
   end

endmodule

/* uart_transmitter.sv */
`timescale 1ns/1ns

module uart_transmitter (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  tx_en_i,
   input  logic [uart_frame_pkg::baud_div_w-1:0] baud_div_i,
   input  logic                                  fifo_empty_i,
   input  logic [uart_frame_pkg::data_bits-1:0]  fifo_data_i,
   output logic                                  fifo_pop_o,
   output logic                                  tx_o,
   output logic                                  tx_busy_o
);

   uart_fsm_pkg::tx_state_t               state;
   logic [uart_frame_pkg::baud_div_w-1:0] period_cnt;
   logic [uart_frame_pkg::bit_cnt_w-1:0]  bit_cnt;
   logic [uart_frame_pkg::data_bits-1:0]  shift_q;
   logic                                  period_end;

   assign period_end = (period_cnt == baud_div_i);
   assign fifo_pop_o = (state == uart_fsm_pkg::tx_idle) && tx_en_i && !fifo_empty_i;
   assign tx_busy_o = (state != uart_fsm_pkg::tx_idle);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state      <= uart_fsm_pkg::tx_idle;
         period_cnt <= '0;
         bit_cnt    <= '0;
         tx_o       <= uart_frame_pkg::line_idle;
      end else begin
         case (state)
            uart_fsm_pkg::tx_idle: begin
               if (fifo_pop_o) begin
                  state      <= uart_fsm_pkg::tx_start;
                  period_cnt <= '0;
                  tx_o       <= uart_frame_pkg::start_bit;
               end
            end
            uart_fsm_pkg::tx_start: begin
               if (period_end) begin
                  state      <= uart_fsm_pkg::tx_data;
                  period_cnt <= '0;
                  bit_cnt    <= '0;
                  tx_o       <= shift_q[0];
               end else begin
                  period_cnt <= period_cnt + 1'b1;
               end
            end
            uart_fsm_pkg::tx_data: begin
               if (period_end) begin
                  period_cnt <= '0;
                  if (bit_cnt == uart_frame_pkg::last_bit) begin
                     state   <= uart_fsm_pkg::tx_stop;
                     bit_cnt <= '0;
                     tx_o    <= uart_frame_pkg::stop_bit;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                     tx_o    <= shift_q[1]; // The register shifts down at this same edge
                  end
               end else begin
                  period_cnt <= period_cnt + 1'b1;
               end
            end
            uart_fsm_pkg::tx_stop: begin
               if (period_end) begin
                  state      <= uart_fsm_pkg::tx_idle;
                  period_cnt <= '0;
                  tx_o       <= uart_frame_pkg::line_idle;
               end else begin
                  period_cnt <= period_cnt + 1'b1;
               end
            end
            default: begin
               state <= uart_fsm_pkg::tx_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (fifo_pop_o) begin
         shift_q <= fifo_data_i;
      end else if ((state == uart_fsm_pkg::tx_data) && period_end) begin
         shift_q <= shift_q >> 1;
      end
   end

endmodule
